/* src/soc_pkg.sv */
// ----------------------------------------------------------------------
// Bus widths, address map, request and response structs, boot ROM image
// ----------------------------------------------------------------------

package soc_pkg;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 64;
    localparam int unsigned BE_W   = DATA_W / 8;
    localparam int unsigned OFFS_W = $clog2(BE_W);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BE_W-1:0]   be_t;

    // One request beat, 105 bits
    typedef struct packed {
        logic  we;
        addr_t addr;
        data_t wdata;
        be_t   be;
    } bus_req_t;

    typedef struct packed {
        data_t rdata;
        logic  err;
    } bus_rsp_t;

    typedef enum logic [2:0] {
        REGION_ROM,
        REGION_CLINT,
        REGION_HOST,
        REGION_DRAM,
        REGION_NONE
    } region_e;

    // ------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------
    localparam addr_t ROM_BASE   = 32'h0001_0000;
    localparam addr_t ROM_LEN    = 32'h0000_1000;
    localparam addr_t CLINT_BASE = 32'h0200_0000;
    localparam addr_t CLINT_LEN  = 32'h0000_C000;
    localparam addr_t HOST_BASE  = 32'h0300_0000;
    localparam addr_t HOST_LEN   = 32'h0000_1000;
    localparam addr_t DRAM_BASE  = 32'h8000_0000;

    // CLINT register offsets, hart 0 only
    localparam addr_t MSIP_OFFS     = 32'h0000_0000;
    localparam addr_t MTIMECMP_OFFS = 32'h0000_4000;
    localparam addr_t MTIME_OFFS    = 32'h0000_BFF8;

    // ------------------------------------------------------------------
    // Boot ROM image
    // ------------------------------------------------------------------
    localparam int unsigned ROM_WORDS = 16;

    typedef data_t rom_image_t [ROM_WORDS];

    function automatic rom_image_t gen_rom_image();
        rom_image_t img;
        for (int i = 0; i < ROM_WORDS; i++) begin
            img[i] = 64'h0B00_7000_0000_0000 + data_t'(i) * 64'h0101;
        end
        return img;
    endfunction

    localparam rom_image_t ROM_IMAGE = gen_rom_image();

    // Replace the enabled bytes of a word
    function automatic data_t be_merge(data_t old_word, data_t new_word, be_t be);
        data_t merged;
        merged = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

/* src/stall_slice.sv */
// ----------------------------------------------------------------------
// One-entry valid/ready slice with optional pseudo-random stall
// ----------------------------------------------------------------------

module stall_slice #(
    parameter type payload_t   = logic,
    parameter bit  StallRandom = 1'b1
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     in_valid_i,
    input  payload_t in_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output payload_t out_o,
    input  logic     out_ready_i
);

    logic        full_q;
    payload_t    data_q;
    logic [15:0] lfsr_q;
    logic        stall;

    // x^16 + x^14 + x^13 + x^11, stall on about a quarter of cycles
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lfsr_q <= 16'hACE1;
        end else begin
            lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        end
    end

    assign stall       = StallRandom && (lfsr_q[1:0] == 2'b00);
    assign out_valid_o = full_q && !stall;
    assign out_o       = data_q;
    assign in_ready_o  = !full_q || (out_valid_o && out_ready_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            full_q <= 1'b1;
        end else if (out_valid_o && out_ready_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_i;
        end
    end

    // A stalled item is offered again unchanged
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_o && !out_ready_i) |=> $stable(out_o))
        else $error("slice output changed under back-pressure");

endmodule

/* src/bus_decoder.sv */
// ----------------------------------------------------------------------
// Address decoder with a single outstanding transaction
// ----------------------------------------------------------------------

module bus_decoder
    import soc_pkg::*;
#(
    parameter int unsigned DramWords = 1024
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     req_valid_i,
    input  bus_req_t req_i,
    output logic     req_ready_o,
    output logic     rsp_valid_o,
    output bus_rsp_t rsp_o,
    output logic     rom_req_o,
    output logic     regs_req_o,
    output bus_req_t tgt_req_o,
    input  data_t    rom_rdata_i,
    input  data_t    regs_rdata_i,
    output logic     dram_valid_o,
    input  logic     dram_ready_i,
    input  logic     dram_rsp_valid_i,
    input  bus_rsp_t dram_rsp_i,
    output logic     dram_rsp_ready_o
);

    localparam addr_t DramLen = addr_t'(DramWords * BE_W);

    region_e  region_d;
    region_e  region_q;
    logic     accept;
    logic     busy_q;
    logic     stb_q;
    logic     rsp_pend_q;
    logic     dram_valid_q;
    bus_req_t req_q;

    function automatic logic in_window(addr_t addr, addr_t base, addr_t len);
        return (addr >= base) && ((addr - base) < len);
    endfunction

    // ROM writes fall into the error region
    always_comb begin
        if (in_window(req_i.addr, ROM_BASE, ROM_LEN)) begin
            region_d = req_i.we ? REGION_NONE : REGION_ROM;
        end else if (in_window(req_i.addr, CLINT_BASE, CLINT_LEN)) begin
            region_d = REGION_CLINT;
        end else if (in_window(req_i.addr, HOST_BASE, HOST_LEN)) begin
            region_d = REGION_HOST;
        end else if (in_window(req_i.addr, DRAM_BASE, DramLen)) begin
            region_d = REGION_DRAM;
        end else begin
            region_d = REGION_NONE;
        end
    end

    assign req_ready_o = !busy_q;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q       <= 1'b0;
            stb_q        <= 1'b0;
            rsp_pend_q   <= 1'b0;
            dram_valid_q <= 1'b0;
            region_q     <= REGION_NONE;
        end else begin
            // Local targets answer one cycle after their strobe
            stb_q      <= accept && (region_d != REGION_DRAM);
            rsp_pend_q <= stb_q;
            if (accept) begin
                busy_q   <= 1'b1;
                region_q <= region_d;
            end else if (rsp_valid_o) begin
                busy_q <= 1'b0;
            end
            if (accept && (region_d == REGION_DRAM)) begin
                dram_valid_q <= 1'b1;
            end else if (dram_ready_i) begin
                dram_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= req_i;
        end
    end

    assign tgt_req_o        = req_q;
    assign rom_req_o        = stb_q && (region_q == REGION_ROM);
    assign regs_req_o       = stb_q && (region_q == REGION_CLINT || region_q == REGION_HOST);
    assign dram_valid_o     = dram_valid_q;
    assign dram_rsp_ready_o = 1'b1;
    assign rsp_valid_o      = rsp_pend_q || dram_rsp_valid_i;

    // Response mux, selected by the region of the pending transaction
    always_comb begin
        rsp_o = '0;
        unique case (region_q)
            REGION_ROM:                rsp_o.rdata = rom_rdata_i;
            REGION_CLINT, REGION_HOST: rsp_o.rdata = regs_rdata_i;
            REGION_DRAM:               rsp_o       = dram_rsp_i;
            default:                   rsp_o.err   = 1'b1;
        endcase
    end

    // Every response belongs to an accepted request, also on the DRAM path
    assert property (@(posedge clk_i) disable iff (!rst_n_i) rsp_valid_o |-> busy_q)
        else $error("response strobe without outstanding request");

endmodule

/* src/dram_ram.sv */
// ----------------------------------------------------------------------
// Byte-enabled DRAM model with registered response
// ----------------------------------------------------------------------

module dram_ram
    import soc_pkg::*;
#(
    parameter int unsigned DramWords = 1024
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     req_valid_i,
    input  bus_req_t req_i,
    output logic     req_ready_o,
    output logic     rsp_valid_o,
    output bus_rsp_t rsp_o,
    input  logic     rsp_ready_i
);

    localparam int unsigned IdxW = $clog2(DramWords);

    data_t           mem_q [DramWords];
    addr_t           offs;
    logic [IdxW-1:0] idx;
    data_t           wr_word;
    logic            accept;
    logic            rsp_valid_q;
    bus_rsp_t        rsp_q;

    assign offs    = req_i.addr - DRAM_BASE;
    assign idx     = offs[OFFS_W +: IdxW];
    assign wr_word = be_merge(mem_q[idx], req_i.wdata, req_i.be);

    // Stall new requests while a result is still waiting
    assign req_ready_o = !rsp_valid_q || rsp_ready_i;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i) begin
        if (accept && req_i.we) begin
            mem_q[idx] <= wr_word;
        end
        if (accept) begin
            rsp_q.rdata <= req_i.we ? wr_word : mem_q[idx];
            rsp_q.err   <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

/* src/boot_rom.sv */
// ----------------------------------------------------------------------
// Boot ROM, registered read of the image
// ----------------------------------------------------------------------

module boot_rom
    import soc_pkg::*;
(
    input  logic  clk_i,
    input  logic  req_i,
    input  addr_t addr_i,
    output data_t rdata_o
);

    localparam int unsigned IdxW = $clog2(ROM_WORDS);

    logic [IdxW-1:0] idx;

    // Image repeats across the whole window
    assign idx = addr_i[OFFS_W +: IdxW];

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_o <= ROM_IMAGE[idx];
        end
    end

endmodule

/* src/sys_regs.sv */
// ----------------------------------------------------------------------
// CLINT timer and software interrupt, host exit register
// ----------------------------------------------------------------------

module sys_regs
    import soc_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        rtc_i,
    input  logic        req_i,
    input  bus_req_t    req_bus_i,
    output data_t       rdata_o,
    output logic        timer_irq_o,
    output logic        ipi_o,
    output logic [31:0] exit_o
);

    logic [1:0]  rtc_sync_q;
    logic        rtc_last_q;
    logic        rtc_tick;
    addr_t       offs;
    logic        sel_msip;
    logic        sel_cmp;
    logic        sel_time;
    logic        sel_host;
    logic        wr;
    logic        msip_q;
    data_t       mtime_q;
    data_t       mtimecmp_q;
    logic [31:0] exit_q;
    data_t       rd_word;

    // Word-level register select
    assign offs     = req_bus_i.addr - CLINT_BASE;
    assign sel_msip = offs[ADDR_W-1:OFFS_W] == MSIP_OFFS[ADDR_W-1:OFFS_W];
    assign sel_cmp  = offs[ADDR_W-1:OFFS_W] == MTIMECMP_OFFS[ADDR_W-1:OFFS_W];
    assign sel_time = offs[ADDR_W-1:OFFS_W] == MTIME_OFFS[ADDR_W-1:OFFS_W];
    assign sel_host = req_bus_i.addr[ADDR_W-1:OFFS_W] == HOST_BASE[ADDR_W-1:OFFS_W];
    assign wr       = req_i && req_bus_i.we;

    // Rising edge of the synchronized rtc
    assign rtc_tick = rtc_sync_q[1] && !rtc_last_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rtc_sync_q <= '0;
            rtc_last_q <= 1'b0;
            msip_q     <= 1'b0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            exit_q     <= '0;
        end else begin
            // Synchronizer, then rising edge detect
            rtc_sync_q <= {rtc_sync_q[0], rtc_i};
            rtc_last_q <= rtc_sync_q[1];
            if (wr && sel_msip && req_bus_i.be[0]) begin
                msip_q <= req_bus_i.wdata[0];
            end
            if (wr && sel_cmp) begin
                mtimecmp_q <= be_merge(mtimecmp_q, req_bus_i.wdata, req_bus_i.be);
            end
            // Software write wins over a tick
            if (wr && sel_time) begin
                mtime_q <= be_merge(mtime_q, req_bus_i.wdata, req_bus_i.be);
            end else if (rtc_tick) begin
                mtime_q <= mtime_q + 1'b1;
            end
            if (wr && sel_host) begin
                exit_q <= req_bus_i.wdata[31:0];
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (sel_msip) begin
            rd_word[0] = msip_q;
        end else if (sel_cmp) begin
            rd_word = mtimecmp_q;
        end else if (sel_time) begin
            rd_word = mtime_q;
        end else if (sel_host) begin
            rd_word[31:0] = exit_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_o <= rd_word;
        end
    end

    assign timer_irq_o = mtime_q >= mtimecmp_q;
    assign ipi_o       = msip_q;
    assign exit_o      = exit_q;

    // mtime only counts up, so the interrupt holds until software moves a register
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (timer_irq_o && !(wr && (sel_cmp || sel_time))) |=> timer_irq_o)
        else $error("timer interrupt dropped without a register write");

endmodule

/* src/soc_top.sv */
// ----------------------------------------------------------------------
// SoC harness top, decoder plus ROM, DRAM path and system registers
// ----------------------------------------------------------------------

module soc_top
    import soc_pkg::*;
#(
    parameter int unsigned DramWords   = 1024,
    parameter bit          StallRandom = 1'b1
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        rtc_i,
    input  logic        req_valid_i,
    input  bus_req_t    req_i,
    output logic        req_ready_o,
    output logic        rsp_valid_o,
    output bus_rsp_t    rsp_o,
    output logic        timer_irq_o,
    output logic        ipi_o,
    output logic [31:0] exit_o
);

    logic     rom_req;
    logic     regs_req;
    bus_req_t tgt_req;
    data_t    rom_rdata;
    data_t    regs_rdata;

    // DRAM path, decoder -> slice -> RAM -> slice -> decoder
    logic     dram_valid;
    logic     dram_ready;
    logic     mem_req_valid;
    logic     mem_req_ready;
    bus_req_t mem_req;
    logic     mem_rsp_valid;
    logic     mem_rsp_ready;
    bus_rsp_t mem_rsp;
    logic     dram_rsp_valid;
    logic     dram_rsp_ready;
    bus_rsp_t dram_rsp;

    bus_decoder #(
        .DramWords ( DramWords )
    ) u_decoder (
        .clk_i            ( clk_i          ),
        .rst_n_i          ( rst_n_i        ),
        .req_valid_i      ( req_valid_i    ),
        .req_i            ( req_i          ),
        .req_ready_o      ( req_ready_o    ),
        .rsp_valid_o      ( rsp_valid_o    ),
        .rsp_o            ( rsp_o          ),
        .rom_req_o        ( rom_req        ),
        .regs_req_o       ( regs_req       ),
        .tgt_req_o        ( tgt_req        ),
        .rom_rdata_i      ( rom_rdata      ),
        .regs_rdata_i     ( regs_rdata     ),
        .dram_valid_o     ( dram_valid     ),
        .dram_ready_i     ( dram_ready     ),
        .dram_rsp_valid_i ( dram_rsp_valid ),
        .dram_rsp_i       ( dram_rsp       ),
        .dram_rsp_ready_o ( dram_rsp_ready )
    );

    stall_slice #(
        .payload_t   ( bus_req_t   ),
        .StallRandom ( StallRandom )
    ) u_req_slice (
        .clk_i       ( clk_i         ),
        .rst_n_i     ( rst_n_i       ),
        .in_valid_i  ( dram_valid    ),
        .in_i        ( tgt_req       ),
        .in_ready_o  ( dram_ready    ),
        .out_valid_o ( mem_req_valid ),
        .out_o       ( mem_req       ),
        .out_ready_i ( mem_req_ready )
    );

    dram_ram #(
        .DramWords ( DramWords )
    ) u_dram (
        .clk_i       ( clk_i         ),
        .rst_n_i     ( rst_n_i       ),
        .req_valid_i ( mem_req_valid ),
        .req_i       ( mem_req       ),
        .req_ready_o ( mem_req_ready ),
        .rsp_valid_o ( mem_rsp_valid ),
        .rsp_o       ( mem_rsp       ),
        .rsp_ready_i ( mem_rsp_ready )
    );

    stall_slice #(
        .payload_t   ( bus_rsp_t   ),
        .StallRandom ( StallRandom )
    ) u_rsp_slice (
        .clk_i       ( clk_i          ),
        .rst_n_i     ( rst_n_i        ),
        .in_valid_i  ( mem_rsp_valid  ),
        .in_i        ( mem_rsp        ),
        .in_ready_o  ( mem_rsp_ready  ),
        .out_valid_o ( dram_rsp_valid ),
        .out_o       ( dram_rsp       ),
        .out_ready_i ( dram_rsp_ready )
    );

    boot_rom u_rom (
        .clk_i   ( clk_i        ),
        .req_i   ( rom_req      ),
        .addr_i  ( tgt_req.addr ),
        .rdata_o ( rom_rdata    )
    );

    sys_regs u_regs (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .rtc_i       ( rtc_i       ),
        .req_i       ( regs_req    ),
        .req_bus_i   ( tgt_req     ),
        .rdata_o     ( regs_rdata  ),
        .timer_irq_o ( timer_irq_o ),
        .ipi_o       ( ipi_o       ),
        .exit_o      ( exit_o      )
    );

endmodule

/* tb/tb_tests.svh */
// ----------------------------------------------------------------------
// Bus driver tasks, reference helpers and directed tests
// ----------------------------------------------------------------------

`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// Expected ROM word, image repeats every 16 words
function automatic data_t rom_word(input int unsigned idx);
    return 64'h0B00_7000_0000_0000 + data_t'(idx % 16) * 64'h0101;
endfunction

function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                      input be_t be);
    data_t mask;
    for (int b = 0; b < 8; b++) begin
        mask[8*b +: 8] = {8{be[b]}};
    end
    return (old_word & ~mask) | (new_word & mask);
endfunction

// ----------------------------------------------------------------------
// Bus driver, called and returning on a falling edge
// ----------------------------------------------------------------------
task automatic transfer(input logic we, input addr_t addr, input data_t wdata,
                        input be_t be, output bus_rsp_t rsp);
    bus_req_t    req;
    int unsigned waited;
    req.we      = we;
    req.addr    = addr;
    req.wdata   = wdata;
    req.be      = be;
    rsp         = '0;
    req_i       = req;
    req_valid_i = 1'b1;
    waited      = 0;
    while (!req_ready_o && waited < Timeout) begin
        @(negedge clk_i);
        waited++;
    end
    if (!req_ready_o) begin
        errors++;
        $display("The DUT did not accept the request at address 0x%h in time", addr);
        req_valid_i = 1'b0;
        return;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    req_valid_i = 1'b0;
    req_i       = '0;
    waited      = 0;
    while (!rsp_valid_o && waited < Timeout) begin
        @(negedge clk_i);
        waited++;
    end
    if (!rsp_valid_o) begin
        errors++;
        $display("No response arrived for the request at address 0x%h", addr);
        return;
    end
    rsp = rsp_o;
endtask

task automatic write_word(input addr_t addr, input data_t wdata, input be_t be,
                          output bus_rsp_t rsp);
    transfer(1'b1, addr, wdata, be, rsp);
endtask

task automatic read_word(input addr_t addr, output bus_rsp_t rsp);
    transfer(1'b0, addr, '0, '0, rsp);
endtask

// Rising rtc edges 8 cycles apart
task automatic pulse_rtc(input int unsigned n);
    for (int i = 0; i < n; i++) begin
        rtc_i = 1'b1;
        repeat (4) @(negedge clk_i);
        rtc_i = 1'b0;
        repeat (4) @(negedge clk_i);
    end
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------
task automatic after_reset();
    check_word("exit_o", exit_o, 32'h0);
    check_bit("timer_irq_o", timer_irq_o, 1'b0);
    check_bit("ipi_o", ipi_o, 1'b0);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
endtask

task automatic rom_reads();
    bus_rsp_t    rsp;
    int unsigned word;
    for (int i = 0; i < 20; i++) begin
        word = $urandom_range(511, 0);
        read_word(ROM_BASE + addr_t'(word * 8), rsp);
        check_err("rsp_o.err", rsp, 1'b0);
        check_data("rsp_o.rdata", rsp.rdata, rom_word(word));
    end
    // ROM is read only
    write_word(ROM_BASE + 32'h40, 64'h1234_5678, 8'hFF, rsp);
    check_err("rsp_o.err", rsp, 1'b1);
endtask

task automatic dram_access();
    int unsigned slot_idx [8];
    data_t       model [8];
    bus_rsp_t    rsp;
    int unsigned s;
    data_t       wdata;
    data_t       exp;
    be_t         be;
    // One word per eighth of the DRAM, so no two slots collide
    for (int i = 0; i < 8; i++) begin
        slot_idx[i] = i * (DramWords / 8) + $urandom_range(DramWords / 8 - 1, 0);
        wdata       = {$urandom, $urandom};
        write_word(DRAM_BASE + addr_t'(slot_idx[i] * 8), wdata, 8'hFF, rsp);
        check_data("rsp_o.rdata", rsp.rdata, wdata);
        model[i] = wdata;
    end
    for (int i = 0; i < 40; i++) begin
        s     = $urandom_range(7, 0);
        wdata = {$urandom, $urandom};
        be    = be_t'($urandom_range(255, 0));
        exp   = merge_bytes(model[s], wdata, be);
        write_word(DRAM_BASE + addr_t'(slot_idx[s] * 8), wdata, be, rsp);
        check_err("rsp_o.err", rsp, 1'b0);
        check_data("rsp_o.rdata", rsp.rdata, exp);
        model[s] = exp;
    end
    for (int i = 0; i < 8; i++) begin
        read_word(DRAM_BASE + addr_t'(slot_idx[i] * 8), rsp);
        check_err("rsp_o.err", rsp, 1'b0);
        check_data("rsp_o.rdata", rsp.rdata, model[i]);
    end
endtask

task automatic unmapped_read();
    bus_rsp_t rsp;
    read_word(32'h4000_0000, rsp);
    check_err("rsp_o.err", rsp, 1'b1);
    check_data("rsp_o.rdata", rsp.rdata, '0);
endtask

task automatic clint_regs();
    bus_rsp_t    rsp;
    int unsigned n;
    write_word(CLINT_BASE + MSIP_OFFS, 64'h1, 8'h01, rsp);
    check_err("rsp_o.err", rsp, 1'b0);
    check_bit("ipi_o", ipi_o, 1'b1);
    // rtc has been low since reset
    read_word(CLINT_BASE + MTIME_OFFS, rsp);
    check_data("mtime", rsp.rdata, '0);
    n = $urandom_range(9, 3);
    pulse_rtc(n);
    read_word(CLINT_BASE + MTIME_OFFS, rsp);
    check_data("mtime", rsp.rdata, data_t'(n));
    write_word(CLINT_BASE + MTIMECMP_OFFS, data_t'(n + 3), 8'hFF, rsp);
    check_err("rsp_o.err", rsp, 1'b0);
    check_bit("timer_irq_o", timer_irq_o, 1'b0);
    pulse_rtc(3);
    check_bit("timer_irq_o", timer_irq_o, 1'b1);
endtask

task automatic host_exit();
    bus_rsp_t rsp;
    write_word(HOST_BASE, 64'h0000_0539, 8'hFF, rsp);
    check_err("rsp_o.err", rsp, 1'b0);
    check_word("exit_o", exit_o, 32'h0000_0539);
    read_word(HOST_BASE, rsp);
    check_data("rsp_o.rdata", rsp.rdata, 64'h0000_0539);
endtask

`endif

/* tb/tb_top.sv */
// ----------------------------------------------------------------------
// Testbench top with clock, reset, DUT, compare tasks and final report
// ----------------------------------------------------------------------

module tb_top
    import soc_pkg::*;
();

    localparam int unsigned DramWords = 1024;
    localparam int unsigned Timeout   = 200;

    logic        clk_i;
    logic        rst_n_i;
    logic        rtc_i;
    logic        req_valid_i;
    bus_req_t    req_i;
    logic        req_ready_o;
    logic        rsp_valid_o;
    bus_rsp_t    rsp_o;
    logic        timer_irq_o;
    logic        ipi_o;
    logic [31:0] exit_o;
    int          errors;

    soc_top #(
        .DramWords ( DramWords )
    ) dut0 (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .rtc_i       ( rtc_i       ),
        .req_valid_i ( req_valid_i ),
        .req_i       ( req_i       ),
        .req_ready_o ( req_ready_o ),
        .rsp_valid_o ( rsp_valid_o ),
        .rsp_o       ( rsp_o       ),
        .timer_irq_o ( timer_irq_o ),
        .ipi_o       ( ipi_o       ),
        .exit_o      ( exit_o      )
    );

    always #10 clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_err(input string name, input bus_rsp_t rsp, input logic exp);
        if (rsp.err !== exp) begin
            errors++;
            $display("error: %s got 0x%h expected 0x%h", name, rsp.err, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    `include "tb_tests.svh"

    initial begin
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        rtc_i       = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        errors      = 0;
        void'($urandom(32'h91d4));
        repeat (16) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        after_reset();
        rom_reads();
        dram_access();
        unmapped_read();
        clint_regs();
        host_exit();

        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+tb
src/soc_pkg.sv
src/stall_slice.sv
src/bus_decoder.sv
src/dram_ram.sv
src/boot_rom.sv
src/sys_regs.sv
src/soc_top.sv
tb/tb_top.sv
